// ==== source/usb_ep_pkg.sv ====
package usb_ep_pkg;

  // USB packet identifiers, low nibble of the PID byte
  typedef logic [3:0] pid_t;

  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;
  localparam pid_t PID_NAK   = 4'b1010;
  localparam pid_t PID_STALL = 4'b1110;

  // Endpoint states
  typedef enum logic [2:0] {
    ST_HALT,  // Not configured, tokens get a STALL
    ST_IDLE,  // Waiting for an IN token
    ST_SEND,  // Streaming packet bytes to the encoder
    ST_NONE,  // Single beat answer: NAK, STALL or ZDP
    ST_WAIT   // Waiting for ACK or timeout
  } ep_state_t;

  // One beat towards the packet encoder
  typedef struct packed {
    pid_t       pid;   // Repeated on every beat of a packet
    logic       keep;  // Low when the beat carries no byte
    logic       last;
    logic [7:0] data;
  } tx_beat_t;

endpackage

// ==== source/output_skid.sv ====
`timescale 1ns/1ps

module output_skid (
  input  logic                 clock,
  input  logic                 reset_i,
  input  logic                 in_valid_i,
  input  usb_ep_pkg::tx_beat_t in_beat_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,
  output usb_ep_pkg::tx_beat_t out_beat_o,
  input  logic                 out_ready_i
);
  import usb_ep_pkg::*;

  tx_beat_t spare_q;
  logic     spare_vld_q;
  logic     out_free;
  logic     push;

  assign in_ready_o = ~spare_vld_q;  // Registered, no path from out_ready_i
  assign push       = in_valid_i && in_ready_o;
  assign out_free   = !out_valid_o || out_ready_i;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
      spare_vld_q <= 1'b0;
    end else if (out_free) begin
      out_valid_o <= spare_vld_q || push;
      spare_vld_q <= 1'b0;
    end else if (push) begin
      spare_vld_q <= 1'b1;  // Output stalled, park the beat
    end
  end

  always_ff @(posedge clock) begin
    if (out_free) begin
      out_beat_o <= spare_vld_q ? spare_q : in_beat_i;
    end else if (push) begin
      spare_q <= in_beat_i;
    end
  end

endmodule

// ==== source/replay_buffer.sv ====
`timescale 1ns/1ps

module replay_buffer #(
  parameter int BUFFER_DEPTH = 2048
) (
  input  logic       clock,
  input  logic       reset_i,
  input  logic       s_valid_i,
  input  logic       s_last_i,
  input  logic [7:0] s_data_i,
  output logic       s_ready_o,
  input  logic       rd_en_i,
  input  logic       commit_i,
  input  logic       rewind_i,
  output logic [7:0] rd_data_o,
  output logic       rd_last_o,
  output logic       frame_ready_o
);

  localparam int AW = $clog2(BUFFER_DEPTH);
  localparam logic [AW:0] FULL_LEVEL = (AW + 1)'(BUFFER_DEPTH);

  logic [7:0] data_mem [BUFFER_DEPTH];
  logic       last_mem [BUFFER_DEPTH];

  // Pointers carry one extra wrap bit
  logic [AW:0] wr_ptr_q;     // Next byte to write
  logic [AW:0] saved_ptr_q;  // End of the last complete frame
  logic [AW:0] rd_ptr_q;     // Next byte to read
  logic [AW:0] com_ptr_q;    // First byte not yet acknowledged
  logic [AW:0] used;
  logic        ready_q;      // Holds the source off for a cycle after reset
  logic        wr_en;

  // Space is counted from the committed pointer so a packet
  // awaiting its ACK stays intact
  assign used      = wr_ptr_q - com_ptr_q;
  assign s_ready_o = ready_q && (used != FULL_LEVEL);
  assign wr_en     = s_valid_i && s_ready_o;

  assign frame_ready_o = rd_ptr_q != saved_ptr_q;  // Saved bytes left to read

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[wr_ptr_q[AW-1:0]] <= s_data_i;
      last_mem[wr_ptr_q[AW-1:0]] <= s_last_i;
    end
  end

  // Read data is registered, valid the cycle after rd_en_i
  always_ff @(posedge clock) begin
    if (rd_en_i) begin
      rd_data_o <= data_mem[rd_ptr_q[AW-1:0]];
      rd_last_o <= last_mem[rd_ptr_q[AW-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      ready_q     <= 1'b0;
      wr_ptr_q    <= '0;
      saved_ptr_q <= '0;
      rd_ptr_q    <= '0;
      com_ptr_q   <= '0;
    end else begin
      ready_q <= 1'b1;

      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        if (s_last_i) begin
          saved_ptr_q <= wr_ptr_q + 1'b1;  // Frame becomes readable
        end
      end

      // Rewind replays everything since the last ACK
      if (rewind_i) begin
        rd_ptr_q <= com_ptr_q;
      end else if (rd_en_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end

      if (commit_i) begin
        com_ptr_q <= rd_ptr_q;  // Frees the acknowledged bytes
      end
    end
  end

endmodule

// ==== source/packet_chunker.sv ====
`timescale 1ns/1ps

module packet_chunker #(
  parameter int MAX_PACKET_SIZE = 512
) (
  input  logic clock,
  input  logic reset_i,
  input  logic byte_read_i,
  input  logic frame_last_i,
  input  logic commit_i,
  input  logic rewind_i,
  output logic pkt_end_o,
  output logic zdp_pending_o
);

  localparam int CW = $clog2(MAX_PACKET_SIZE + 1);
  localparam logic [CW-1:0] FULL_COUNT = CW'(MAX_PACKET_SIZE);

  // Bytes read so far in the current packet, the presented byte included
  logic [CW-1:0] count_q;
  logic          zdp_q;
  logic          full_q;

  assign full_q        = count_q == FULL_COUNT;
  assign pkt_end_o     = frame_last_i || full_q;
  assign zdp_pending_o = zdp_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      count_q <= '0;
      zdp_q   <= 1'b0;
    end else begin
      // Both handshakes start a fresh packet
      if (commit_i || rewind_i) begin
        count_q <= '0;
      end else if (byte_read_i) begin
        count_q <= count_q + 1'b1;
      end

      // The last byte read is still on frame_last_i while waiting for the ACK.
      // A committed ZDP has a zero count, so it clears the flag
      if (commit_i) begin
        zdp_q <= frame_last_i && full_q;
      end
    end
  end

endmodule

// ==== source/bulk_in_fsm.sv ====
`timescale 1ns/1ps

module bulk_in_fsm (
  input  logic                 clock,
  input  logic                 reset_i,
  input  logic                 selected_i,
  input  logic                 ack_recv_i,
  input  logic                 timedout_i,
  input  logic                 set_conf_i,
  input  logic                 clr_conf_i,
  input  logic                 frame_ready_i,
  input  logic                 pkt_end_i,
  input  logic                 zdp_pending_i,
  input  logic [7:0]           rd_data_i,
  input  logic                 skid_ready_i,
  output logic                 rd_en_o,
  output logic                 commit_o,
  output logic                 rewind_o,
  output logic                 skid_valid_o,
  output usb_ep_pkg::tx_beat_t skid_beat_o,
  output logic                 stalled_o
);
  import usb_ep_pkg::*;

  ep_state_t state_q;
  ep_state_t state_d;
  logic      configured_q;
  logic      toggle_q;     // Low selects DATA0
  logic      byte_vld_q;   // rd_data_i holds a byte not yet given to the skid
  pid_t      pid_q;        // PID of the answer in progress
  pid_t      data_pid;
  logic      sending;
  logic      accept;
  logic      pid_is_data;

  assign sending     = state_q == ST_SEND;
  assign data_pid    = toggle_q ? PID_DATA1 : PID_DATA0;
  assign pid_is_data = (pid_q == PID_DATA0) || (pid_q == PID_DATA1);
  assign stalled_o   = ~configured_q;

  assign skid_valid_o = (sending && byte_vld_q) || state_q == ST_NONE;
  assign accept       = skid_valid_o && skid_ready_i;

  // Fetch ahead only while the presented byte is not the packet's last
  assign rd_en_o  = sending && skid_ready_i && (!byte_vld_q || !pkt_end_i);
  assign commit_o = state_q == ST_WAIT && ack_recv_i;
  assign rewind_o = state_q == ST_WAIT && timedout_i && !ack_recv_i;

  always_comb begin
    skid_beat_o.pid  = pid_q;
    skid_beat_o.keep = sending;
    skid_beat_o.last = !sending || pkt_end_i;  // Handshakes and ZDPs are one beat
    skid_beat_o.data = sending ? rd_data_i : 8'h00;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_HALT: begin
        if (selected_i) state_d = ST_NONE;  // Answer with STALL
        else if (set_conf_i) state_d = ST_IDLE;
      end
      ST_IDLE: begin
        if (!configured_q || clr_conf_i) begin
          state_d = ST_HALT;
        end else if (selected_i) begin
          state_d = (frame_ready_i && !zdp_pending_i) ? ST_SEND : ST_NONE;
        end
      end
      ST_SEND: if (accept && pkt_end_i) state_d = ST_WAIT;
      ST_NONE: begin
        // A ZDP needs a handshake, NAK and STALL do not
        if (accept) state_d = pid_is_data ? ST_WAIT : (configured_q ? ST_IDLE : ST_HALT);
      end
      ST_WAIT: if (ack_recv_i || timedout_i) state_d = ST_IDLE;
      default: state_d = ST_HALT;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q      <= ST_HALT;
      configured_q <= 1'b0;
      toggle_q     <= 1'b0;
      byte_vld_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (clr_conf_i) configured_q <= 1'b0;
      else if (set_conf_i) configured_q <= 1'b1;
      if (set_conf_i) toggle_q <= 1'b0;
      else if (commit_o) toggle_q <= ~toggle_q;  // Flip only on ACK
      if (rd_en_o) byte_vld_q <= 1'b1;
      else if (accept && sending) byte_vld_q <= 1'b0;
    end
  end

  // PID is chosen when the token is taken
  always_ff @(posedge clock) begin
    if (state_q == ST_HALT && selected_i) begin
      pid_q <= PID_STALL;
    end else if (state_q == ST_IDLE && selected_i) begin
      pid_q <= (frame_ready_i || zdp_pending_i) ? data_pid : PID_NAK;
    end
  end

endmodule

// ==== source/ep_bulk_in_top.sv ====
`timescale 1ns/1ps

module ep_bulk_in_top #(
  parameter int MAX_PACKET_SIZE = 512,
  parameter int BUFFER_DEPTH    = 2048
) (
  input  logic                 clock,
  input  logic                 reset_i,
  input  logic                 s_valid_i,
  output logic                 s_ready_o,
  input  logic                 s_last_i,
  input  logic [7:0]           s_data_i,
  output logic                 m_valid_o,
  input  logic                 m_ready_i,
  output usb_ep_pkg::tx_beat_t m_beat_o,
  input  logic                 selected_i,
  input  logic                 ack_recv_i,
  input  logic                 timedout_i,
  input  logic                 set_conf_i,
  input  logic                 clr_conf_i,
  output logic                 stalled_o
);
  import usb_ep_pkg::*;

  logic       frame_ready;
  logic       rd_en;
  logic       commit;
  logic       rewind;
  logic [7:0] rd_data;
  logic       rd_last;
  logic       pkt_end;
  logic       zdp_pending;
  logic       skid_valid;
  logic       skid_ready;
  tx_beat_t   skid_beat;

  bulk_in_fsm i_bulk_in_fsm (
    .clock         (clock),
    .reset_i       (reset_i),
    .selected_i    (selected_i),
    .ack_recv_i    (ack_recv_i),
    .timedout_i    (timedout_i),
    .set_conf_i    (set_conf_i),
    .clr_conf_i    (clr_conf_i),
    .frame_ready_i (frame_ready),
    .pkt_end_i     (pkt_end),
    .zdp_pending_i (zdp_pending),
    .rd_data_i     (rd_data),
    .skid_ready_i  (skid_ready),
    .rd_en_o       (rd_en),
    .commit_o      (commit),
    .rewind_o      (rewind),
    .skid_valid_o  (skid_valid),
    .skid_beat_o   (skid_beat),
    .stalled_o     (stalled_o)
  );

  // Counts on each read request, the byte shows up one cycle later
  packet_chunker #(
    .MAX_PACKET_SIZE (MAX_PACKET_SIZE)
  ) i_packet_chunker (
    .clock         (clock),
    .reset_i       (reset_i),
    .byte_read_i   (rd_en),
    .frame_last_i  (rd_last),
    .commit_i      (commit),
    .rewind_i      (rewind),
    .pkt_end_o     (pkt_end),
    .zdp_pending_o (zdp_pending)
  );

  replay_buffer #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) i_replay_buffer (
    .clock         (clock),
    .reset_i       (reset_i),
    .s_valid_i     (s_valid_i),
    .s_last_i      (s_last_i),
    .s_data_i      (s_data_i),
    .s_ready_o     (s_ready_o),
    .rd_en_i       (rd_en),
    .commit_i      (commit),
    .rewind_i      (rewind),
    .rd_data_o     (rd_data),
    .rd_last_o     (rd_last),
    .frame_ready_o (frame_ready)
  );

  output_skid i_output_skid (
    .clock       (clock),
    .reset_i     (reset_i),
    .in_valid_i  (skid_valid),
    .in_beat_i   (skid_beat),
    .in_ready_o  (skid_ready),
    .out_valid_o (m_valid_o),
    .out_beat_o  (m_beat_o),
    .out_ready_i (m_ready_i)
  );

endmodule

// ==== verification/ep_bulk_in_tb.sv ====
`timescale 1ns/1ps

module ep_bulk_in_tb;
  import usb_ep_pkg::*;

  logic       clock = 1'b0;
  logic       reset_i;
  logic       s_valid_i;
  logic       s_ready_o;
  logic       s_last_i;
  logic [7:0] s_data_i;
  logic       m_valid_o;
  logic       m_ready_i;
  tx_beat_t   m_beat_o;
  logic       selected_i;
  logic       ack_recv_i;
  logic       timedout_i;
  logic       set_conf_i;
  logic       clr_conf_i;
  logic       stalled_o;

  logic [15:0] vec_mem [64];  // Command, PID, byte count
  tx_beat_t    beat_q[$];     // Beats taken by the encoder
  logic [7:0]  ref_q[$];      // Written bytes not yet acknowledged
  logic [7:0]  byte_cnt = 8'h00;
  int          n_vec;
  int          inflight = 0;  // Bytes of the packet awaiting its handshake
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  ep_bulk_in_top #(
    .MAX_PACKET_SIZE (8),
    .BUFFER_DEPTH    (64)
  ) i_ep_bulk_in_top (
    .clock      (clock),
    .reset_i    (reset_i),
    .s_valid_i  (s_valid_i),
    .s_ready_o  (s_ready_o),
    .s_last_i   (s_last_i),
    .s_data_i   (s_data_i),
    .m_valid_o  (m_valid_o),
    .m_ready_i  (m_ready_i),
    .m_beat_o   (m_beat_o),
    .selected_i (selected_i),
    .ack_recv_i (ack_recv_i),
    .timedout_i (timedout_i),
    .set_conf_i (set_conf_i),
    .clr_conf_i (clr_conf_i),
    .stalled_o  (stalled_o)
  );

  always #10 clock = ~clock;

  // Encoder stalls on about a quarter of the cycles
  initial begin
    void'($urandom(34));
    m_ready_i = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      m_ready_i = ($urandom % 4) != 0;
    end
  end

  // Outputs are stable at the falling edge before the transfer
  always @(negedge clock) begin
    if (!reset_i && m_valid_o && m_ready_i) beat_q.push_back(m_beat_o);
  end

  initial begin
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clock);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles, the endpoint stopped responding", cycle_cnt);
    $display("** FAIL **");
    $finish;
  end

  function automatic void report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    err_cnt++;
  endfunction

  task automatic write_frame(input int len);
    logic took;
    for (int i = 0; i < len; i++) begin
      s_valid_i = 1'b1;
      s_data_i  = byte_cnt;
      s_last_i  = i == len - 1;
      took      = 1'b0;
      while (!took) begin
        @(negedge clock);
        took = s_ready_o;
        @(posedge clock);
        #1;
      end
      ref_q.push_back(byte_cnt);
      byte_cnt++;
    end
    s_valid_i = 1'b0;
    s_last_i  = 1'b0;
  endtask

  // Controller pulses and the reference model update after each handshake
  task automatic pulse_ctrl(input logic [3:0] cmd);
    set_conf_i = cmd == 4'h1;
    clr_conf_i = cmd == 4'h2;
    ack_recv_i = cmd == 4'h5;
    timedout_i = cmd == 4'h6;
    @(posedge clock);
    #1;
    set_conf_i = 1'b0;
    clr_conf_i = 1'b0;
    ack_recv_i = 1'b0;
    timedout_i = 1'b0;
    if (cmd == 4'h5) repeat (inflight) void'(ref_q.pop_front());
    inflight = 0;  // A timeout keeps the bytes for the replay
    assert (beat_q.size() == 0) else report_mismatch("extra beat after the answer");
  endtask

  // Zero expected bytes means a single beat without payload
  task automatic run_token(input pid_t exp_pid, input int exp_len);
    tx_beat_t   beat;
    logic [7:0] exp_byte;
    int         n;
    int         errs_before;
    logic       done;
    errs_before = err_cnt;
    n           = 0;
    done        = 1'b0;
    assert (beat_q.size() == 0) else report_mismatch("beat seen before the token");
    assert (stalled_o == (exp_pid == PID_STALL))
      else report_mismatch($sformatf("stalled_o is %b", stalled_o));
    selected_i = 1'b1;
    @(posedge clock);
    #1;
    selected_i = 1'b0;
    while (!done) begin
      @(posedge clock);
      while (beat_q.size() > 0 && !done) begin
        beat = beat_q.pop_front();
        assert (beat.pid == exp_pid)
          else report_mismatch($sformatf("beat %0d PID %h, expected %h", n, beat.pid, exp_pid));
        if (exp_len == 0) begin
          assert (!beat.keep && beat.last)
            else report_mismatch("handshake or ZDP beat needs keep low and last high");
        end else begin
          exp_byte = n < ref_q.size() ? ref_q[n] : 8'h00;
          assert (beat.keep && beat.data == exp_byte)
            else report_mismatch($sformatf("beat %0d data %h keep %b, expected %h",
                                           n, beat.data, beat.keep, exp_byte));
          assert (beat.last == (n == exp_len - 1))
            else report_mismatch($sformatf("beat %0d has last %b", n, beat.last));
        end
        n++;
        done = beat.last || n >= (exp_len == 0 ? 1 : exp_len);
      end
    end
    #1;
    inflight = exp_len;
    test_cnt++;
    if (err_cnt != errs_before) fail_cnt++;
    $display("Token %0d: PID %h, %0d bytes, %s", test_cnt, exp_pid, exp_len,
             err_cnt == errs_before ? "ok" : "errors");
  endtask

  initial begin
    reset_i    = 1'b1;
    s_valid_i  = 1'b0;
    s_last_i   = 1'b0;
    s_data_i   = 8'h00;
    selected_i = 1'b0;
    ack_recv_i = 1'b0;
    timedout_i = 1'b0;
    set_conf_i = 1'b0;
    clr_conf_i = 1'b0;
    $readmemh("verification/bulk_in_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < 64 && vec_mem[n_vec][15:12] != 4'hF) n_vec++;
    cycle_limit = 200 * n_vec;
    repeat (8) @(posedge clock);
    #1;
    reset_i = 1'b0;
    assert (!m_valid_o && !s_ready_o) else report_mismatch("outputs active in the first cycle");
    @(posedge clock);
    #1;
    assert (s_ready_o) else report_mismatch("s_ready_o low after the first cycle");
    for (int i = 0; i < n_vec; i++) begin
      case (vec_mem[i][15:12])
        4'h1, 4'h2, 4'h5, 4'h6: pulse_ctrl(vec_mem[i][15:12]);
        4'h3: write_frame(int'(vec_mem[i][7:0]));
        4'h4: run_token(vec_mem[i][11:8], int'(vec_mem[i][7:0]));
        default: begin
          $display("Vector line %0d holds an unknown command", i);
          err_cnt++;
        end
      endcase
    end
    repeat (20) @(posedge clock);
    #1;
    assert (beat_q.size() == 0) else report_mismatch("stray beats at the end of the run");
    $display("%0d tests, %0d failed, %0d check errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
source/usb_ep_pkg.sv
source/output_skid.sv
source/replay_buffer.sv
source/packet_chunker.sv
source/bulk_in_fsm.sv
source/ep_bulk_in_top.sv
verification/ep_bulk_in_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bulk IN endpoint testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module ep_bulk_in_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vep_bulk_in_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== verification/bulk_in_vectors.txt ====
// Each word: command digit, expected PID digit, byte count in two hex digits
// Commands: 1 configure, 2 unconfigure, 3 write frame, 4 token, 5 ack, 6 timeout, F end
4E00  // Not configured yet, STALL
1000
4A00  // Configured but nothing stored, NAK
3005
4305
5000
3014  // 20 bytes go out as 8, 8 and 4
4B08
5000
4308
6000  // Lost handshake, same packet and PID again
4308
5000
4B04
5000
3010  // 16 bytes end on a packet boundary
4308
5000
4B08
5000
4300  // ZDP with the current data PID
5000
4A00
2000
4E00  // Stalled again after unconfigure
F000
